/* src/besm_pkg.sv */
package besm_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int UADDR_W      = 12;                       // Microaddress width
    localparam int USTORE_DEPTH = 4096;                     // Control store words
    localparam int STACK_DEPTH  = 5;                        // Am2910 stack entries
    localparam int SP_W         = $clog2(STACK_DEPTH + 1);  // Pointer counts 0..5
    localparam int DATA_W       = 64;                       // Datapath and bus width
    localparam int NREGS        = 16;                       // Register file size
    localparam int RADDR_W      = $clog2(NREGS);            // Register address width
    localparam int RR_W         = 32;                       // Mode register width

    // ------------------------------------------------------------
    // Microword field encodings
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        SEQ_JZ   = 4'd0,            // Jump to zero, clear stack
        SEQ_CJS  = 4'd1,            // Conditional jump to subroutine
        SEQ_CJP  = 4'd3,            // Conditional jump via pipeline
        SEQ_CRTN = 4'd10,           // Conditional return
        SEQ_CONT = 4'd14            // Continue
    } t_seq_op;

    typedef enum logic [4:0] {
        COND_YES    = 5'd0,         // Always true
        COND_NORMB  = 5'd1,         // RR bit 1
        COND_RNDB   = 5'd2,         // RR bit 2
        COND_CT     = 5'd11,        // Stored zero flag
        COND_RUN    = 5'd16,        // Start level from outside
        COND_ARBRDY = 5'd21         // External bus ready
    } t_cond;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,           // A minus B
        ALU_AND   = 3'd2,
        ALU_XOR   = 3'd3,
        ALU_PASSD = 3'd4            // D bus straight to Y
    } t_alu_op;

    typedef enum logic [1:0] {
        DSRC_EXT = 2'd0,            // External data word
        DSRC_IMM = 2'd1,            // A field, zero extended
        DSRC_RR  = 2'd2             // Mode register
    } t_dsrc;

    // Bit positions for a 41-bit word, sqi at the top
    typedef struct packed {
        t_seq_op              sqi;      // [40:37] Sequencer op
        logic [UADDR_W-1:0]   a;        // [36:25] Target or immediate
        t_cond                cond;     // [24:20] Condition select
        logic                 icc;      // [19] Invert condition
        t_alu_op              func;     // [18:16] ALU function
        logic                 alus;     // [15] B operand from D
        logic [RADDR_W-1:0]   ra;       // [14:11] Register A
        logic [RADDR_W-1:0]   rb;       // [10:7] Register B
        logic                 wrb;      // [6] Write Y to RB
        logic                 cem;      // [5] Load zero flag
        t_dsrc                dsrc;     // [4:3] D source
        logic                 ydst_rr;  // [2] Load RR from Y
        logic                 rd;       // [1] External read
        logic                 wr;       // [0] External write
    } t_microword;

    localparam int UWORD_W = $bits(t_microword);           // Stored word width

endpackage

/* src/microsequencer.sv */
`timescale 1ns/10ps

module microsequencer import besm_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  t_microword         i_uword,         // Current pipeline word
    input  logic               i_condition,     // Tested condition, after icc
    output logic [UADDR_W-1:0] o_uaddr          // Next microaddress
);

    logic [UADDR_W-1:0] upc;                    // Address of word in pipeline
    logic [UADDR_W-1:0] upc_inc;                // Fall-through address
    logic [UADDR_W-1:0] stack [STACK_DEPTH];    // Return addresses
    logic [SP_W-1:0]    sp;                     // Entries in use
    logic [SP_W-1:0]    top_idx;                // Index of stack top
    logic               full;
    logic               push;
    logic               pop;
    logic               clear;                  // JZ empties the stack

    assign upc_inc = upc + UADDR_W'(1);
    assign full    = (sp == SP_W'(STACK_DEPTH));
    assign top_idx = (sp == '0) ? '0 : sp - SP_W'(1);   // Empty reads entry 0

    // ------------------------------------------------------------
    // Next address select
    // ------------------------------------------------------------
    always_comb begin
        o_uaddr = upc_inc;                      // Default continue
        push    = 1'b0;
        pop     = 1'b0;
        clear   = 1'b0;
        case (i_uword.sqi)
            SEQ_JZ: begin
                o_uaddr = '0;
                clear   = 1'b1;
            end
            SEQ_CJS: if (i_condition) begin
                o_uaddr = i_uword.a;
                push    = ~full;                // Full stack drops the push
            end
            SEQ_CJP: if (i_condition) begin
                o_uaddr = i_uword.a;
            end
            SEQ_CRTN: if (i_condition) begin
                o_uaddr = stack[top_idx];
                pop     = (sp != '0);
            end
            SEQ_CONT: o_uaddr = upc_inc;
            default:  o_uaddr = upc_inc;        // Unused codes continue
        endcase
    end

    // ------------------------------------------------------------
    // uPC and stack pointer
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            upc <= '0;
            sp  <= '0;
        end else begin
            upc <= o_uaddr;                     // Tracks the fetched word
            if (clear)     sp <= '0;
            else if (push) sp <= sp + SP_W'(1);
            else if (pop)  sp <= sp - SP_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (push) stack[sp] <= upc_inc;         // Return past the CJS
    end

endmodule

/* src/control_store.sv */
`timescale 1ns/10ps

module control_store import besm_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [UADDR_W-1:0] i_uaddr,         // From the sequencer
    output t_microword         o_uword          // Pipeline register
);

    // ------------------------------------------------------------
    // Microcode ROM
    // ------------------------------------------------------------
    logic [UWORD_W-1:0] rom [USTORE_DEPTH];     // One microword per address

    initial begin
        $readmemh("microcode.mem", rom);
    end

    // ------------------------------------------------------------
    // Pipeline register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_uword <= '0;                      // JZ with no enables
        end else begin
            o_uword <= t_microword'(rom[i_uaddr]);
        end
    end

endmodule

/* src/condition_unit.sv */
`timescale 1ns/10ps

module condition_unit import besm_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  t_microword        i_uword,
    input  logic [DATA_W-1:0] i_y,              // ALU result, RR source
    input  logic              i_zero,           // Stored zero flag
    input  logic              i_ready,          // External bus ready
    input  logic              i_run,            // Start level
    output logic              o_condition,      // To the sequencer
    output logic [RR_W-1:0]   o_rr              // To the D bus select
);

    logic [RR_W-1:0] rr;                        // Mode register
    logic            normb;                     // Normalization block
    logic            rndb;                      // Rounding block
    logic            condmux;                   // Selected source, before icc

    // ------------------------------------------------------------
    // Mode register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rr <= '0;
        end else if (i_uword.ydst_rr) begin
            rr <= i_y[RR_W-1:0];                // Low half of Y
        end
    end

    assign normb = rr[1];
    assign rndb  = rr[2];
    assign o_rr  = rr;

    // ------------------------------------------------------------
    // Condition multiplexer
    // ------------------------------------------------------------
    always_comb begin
        case (i_uword.cond)
            COND_YES:    condmux = 1'b1;
            COND_NORMB:  condmux = normb;
            COND_RNDB:   condmux = rndb;
            COND_CT:     condmux = i_zero;      // Stands in for CT
            COND_RUN:    condmux = i_run;
            COND_ARBRDY: condmux = i_ready;
            default:     condmux = 1'b1;        // Unused selects test true
        endcase
    end

    assign o_condition = condmux ^ i_uword.icc;

endmodule

/* src/datapath.sv */
`timescale 1ns/10ps

module datapath import besm_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  t_microword        i_uword,
    input  logic [DATA_W-1:0] i_data,           // External word
    input  logic [RR_W-1:0]   i_rr,             // Mode register
    output logic [DATA_W-1:0] o_y,              // ALU result
    output logic              o_zero,           // Stored Y-is-zero
    output logic [DATA_W-1:0] o_ad,             // Registered write data
    output logic              o_wr,             // Write strobe, one cycle late
    output logic              o_rd              // Read strobe
);

    logic [DATA_W-1:0] regs [NREGS];            // Register file
    logic [DATA_W-1:0] d_bus;                   // D source
    logic [DATA_W-1:0] op_a;                    // Register RA
    logic [DATA_W-1:0] op_b;                    // RB or D
    logic [DATA_W-1:0] y;
    logic              zero_q;

    // ------------------------------------------------------------
    // D bus select
    // ------------------------------------------------------------
    always_comb begin
        case (i_uword.dsrc)
            DSRC_EXT: d_bus = i_data;
            DSRC_IMM: d_bus = DATA_W'(i_uword.a);   // Zero extend
            DSRC_RR:  d_bus = DATA_W'(i_rr);
            default:  d_bus = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Operands and ALU
    // ------------------------------------------------------------
    assign op_a = regs[i_uword.ra];
    assign op_b = i_uword.alus ? d_bus : regs[i_uword.rb];

    always_comb begin
        case (i_uword.func)
            ALU_ADD:   y = op_a + op_b;
            ALU_SUB:   y = op_a - op_b;         // Zero when equal
            ALU_AND:   y = op_a & op_b;
            ALU_XOR:   y = op_a ^ op_b;
            ALU_PASSD: y = d_bus;
            default:   y = op_a;                // Unused codes pass A
        endcase
    end

    assign o_y = y;

    // Register write on wrb
    always_ff @(posedge clk) begin
        if (i_uword.wrb) regs[i_uword.rb] <= y;
    end

    // ------------------------------------------------------------
    // Zero flag and bus strobes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            zero_q <= 1'b0;
            o_wr   <= 1'b0;
        end else begin
            if (i_uword.cem) zero_q <= (y == '0);
            o_wr <= i_uword.wr;
        end
    end

    always_ff @(posedge clk) begin
        if (i_uword.wr) o_ad <= y;              // Held until next write
    end

    assign o_zero = zero_q;
    assign o_rd   = i_uword.rd;                 // Same cycle as sampling

endmodule

/* src/cpu.sv */
`timescale 1ns/10ps

module cpu import besm_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] i_data,           // External word
    input  logic              i_ready,          // Word valid
    input  logic              i_run,            // Start level
    output logic [DATA_W-1:0] o_ad,             // Write data
    output logic              o_wr,             // Write strobe
    output logic              o_rd              // Read strobe
);

    t_microword         uword;                  // Pipeline register
    logic [UADDR_W-1:0] uaddr;                  // Next microaddress
    logic               condition;
    logic [DATA_W-1:0]  y;
    logic               zero;
    logic [RR_W-1:0]    rr;

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    microsequencer u_seq (
        .clk(clk), .reset(reset), .i_uword(uword),
        .i_condition(condition), .o_uaddr(uaddr)
    );

    control_store u_store (
        .clk(clk), .reset(reset), .i_uaddr(uaddr), .o_uword(uword)
    );

    condition_unit u_cond (
        .clk(clk), .reset(reset), .i_uword(uword), .i_y(y), .i_zero(zero),
        .i_ready(i_ready), .i_run(i_run), .o_condition(condition), .o_rr(rr)
    );

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    datapath u_dp (
        .clk(clk), .reset(reset), .i_uword(uword), .i_data(i_data), .i_rr(rr),
        .o_y(y), .o_zero(zero), .o_ad(o_ad), .o_wr(o_wr), .o_rd(o_rd)
    );

endmodule

/* sim/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb import besm_pkg::*; ();

    // ------------------------------------------------------------
    // Run length and stimulus constants
    // ------------------------------------------------------------
    localparam int          NPAIRS          = 40;
    localparam int          NWORDS          = 2 * NPAIRS;       // A then B per pair
    localparam int          NOUT            = 4 * NPAIRS;       // Four writes per pair
    localparam int          CYCLES_PER_PAIR = 40;
    localparam int          CYCLE_LIMIT     = NPAIRS * CYCLES_PER_PAIR;
    localparam int          RESET_CYCLES    = 5;
    localparam int          IDLE_CYCLES     = 12;               // Run held low after reset
    localparam int          DRAIN_CYCLES    = 20;               // Watch for extra writes
    localparam logic [31:0] SEED            = 32'h970f0f9c;
    localparam logic [31:0] LFSR_MASK       = 32'hD0000001;     // Maximal length taps

    typedef struct packed {
        logic [DATA_W-1:0] sum;                 // A + B
        logic [DATA_W-1:0] mix;                 // A ^ B
        logic [DATA_W-1:0] cmp;                 // 1 or A AND B
        logic [DATA_W-1:0] mode;                // 2 or 3 from B bit 1
    } t_expect;

    logic              clk;
    logic              reset;
    logic [DATA_W-1:0] i_data;
    logic              i_ready;
    logic              i_run;
    logic [DATA_W-1:0] o_ad;
    logic              o_wr;
    logic              o_rd;

    logic [31:0]       lfsr;
    logic [DATA_W-1:0] words    [NWORDS];       // Operand stream
    int                gaps     [NWORDS];       // Ready-low cycles before each word
    logic [DATA_W-1:0] exp_vals [NOUT];         // Expected write sequence
    logic              running  = 1'b0;
    int                rd_count = 0;
    int                wr_count = 0;
    int                val_errors   = 0;
    int                proto_errors = 0;
    int                cycles       = 0;

    cpu cpu_i (
        .clk(clk), .reset(reset), .i_data(i_data), .i_ready(i_ready), .i_run(i_run),
        .o_ad(o_ad), .o_wr(o_wr), .o_rd(o_rd)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                      // 100 ns period

    // ------------------------------------------------------------
    // Random source and reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_MASK;
        end else begin
            return s >> 1;
        end
    endfunction

    // One LFSR step per bit taken
    function automatic logic [DATA_W-1:0] rand_bits(input int n);
        logic [DATA_W-1:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[DATA_W-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic t_expect expected_outputs(input logic [DATA_W-1:0] a,
                                                 input logic [DATA_W-1:0] b);
        t_expect e;
        e.sum  = a + b;
        e.mix  = a ^ b;
        e.cmp  = (a == b) ? DATA_W'(1) : (a & b);   // Zero flag branch
        e.mode = b[1] ? DATA_W'(2) : DATA_W'(3);    // NORMB branch
        return e;
    endfunction

    task automatic finish_run(input logic timed_out);
        if (wr_count != NOUT) begin
            $display("Saw %0d writes where %0d were expected", wr_count, NOUT);
        end
        $display("Errors: value %0d, protocol %0d, writes %0d of %0d",
                 val_errors, proto_errors, wr_count, NOUT);
        if (!timed_out && val_errors == 0 && proto_errors == 0 && wr_count == NOUT) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // ------------------------------------------------------------
    // Stimulus, all inputs change on the falling edge
    // ------------------------------------------------------------
    initial begin
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        t_expect           e;
        reset   = 1'b1;
        i_run   = 1'b0;
        i_ready = 1'b0;
        i_data  = '0;
        lfsr    = SEED;
        for (int p = 0; p < NPAIRS; p++) begin
            a = rand_bits(DATA_W);
            b = (p % 4 == 3) ? a : rand_bits(DATA_W);   // Every fourth pair equal
            words[2*p]   = a;
            words[2*p+1] = b;
            gaps[2*p]    = int'(rand_bits(3));
            gaps[2*p+1]  = int'(rand_bits(3));
            e = expected_outputs(a, b);
            exp_vals[4*p]   = e.sum;
            exp_vals[4*p+1] = e.mix;
            exp_vals[4*p+2] = e.cmp;
            exp_vals[4*p+3] = e.mode;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset   = 1'b0;
        i_data  = words[0];                     // First word offered before run
        i_ready = 1'b1;
        repeat (IDLE_CYCLES) @(negedge clk);   // Nothing may move here
        i_run   = 1'b1;
        running = 1'b1;
        for (int w = 0; w < NWORDS; w++) begin
            if (w > 0) begin
                repeat (gaps[w]) @(negedge clk);    // Ready low between words
            end
            i_data  = words[w];
            i_ready = 1'b1;
            while (rd_count <= w) @(negedge clk);   // Held until read edge
            i_ready = 1'b0;
        end
        wait (wr_count == NOUT);
        repeat (DRAIN_CYCLES) @(negedge clk);
        finish_run(1'b0);
    end

    // ------------------------------------------------------------
    // Compare process, samples pre-edge values
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (!reset) begin
            if (o_rd) begin
                if (!i_ready) begin
                    proto_errors = proto_errors + 1;
                    $display("Read strobe high while ready was low at %0t", $time);
                end
                if (!running) begin
                    proto_errors = proto_errors + 1;
                    $display("Read strobe rose before run at %0t", $time);
                end
                rd_count = rd_count + 1;
            end
            if (o_wr) begin
                if (!running) begin
                    proto_errors = proto_errors + 1;
                    $display("Write strobe rose before run at %0t", $time);
                end
                if (wr_count >= NOUT) begin
                    proto_errors = proto_errors + 1;
                    $display("Extra write of %h after the last expected one", o_ad);
                end else if (o_ad !== exp_vals[wr_count]) begin
                    val_errors = val_errors + 1;
                    $display("[ERROR] o_ad write %0d: expected %h, actual %h",
                             wr_count, exp_vals[wr_count], o_ad);
                end
                wr_count = wr_count + 1;
            end
        end
    end

    // Cycle counter and timeout
    always @(posedge clk) begin
        if (!reset) begin
            cycles = cycles + 1;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Run timed out after %0d cycles with %0d of %0d writes seen",
                         cycles, wr_count, NOUT);
                finish_run(1'b1);
            end
        end
    end

endmodule

/* files.f */
src/besm_pkg.sv
src/microsequencer.sv
src/control_store.sv
src/condition_unit.sv
src/datapath.sv
src/cpu.sv
sim/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build the cpu testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module cpu_tb -f files.f -o cpu_tb_sim

# The microcode image is read relative to the working directory
./obj_dir/cpu_tb_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* microcode.mem */
// One 41-bit microword per line, hex, address in the comment
// Fields from the top: sqi a cond icc func alus ra rb wrb cem dsrc ydst_rr rd wr
06001080000 // 0  CJP to self while RUN is low
06003580000 // 1  CJP to self while ARBRDY is low
1C000040042 // 2  Read A into R0
06007580000 // 3  CJP to self while ARBRDY is low
1C0000400C2 // 4  Read B into R1
02020000000 // 5  CJS to 16
1C0000100A0 // 6  R0 - R1, load zero flag
06014B00000 // 7  CJP to 10 on CT
1C000020081 // 8  Write R0 AND R1
06016000000 // 9  CJP to 11
1C002040009 // 10 Write immediate 1
1C000020884 // 11 RR from R1
0601C100000 // 12 CJP to 14 on NORMB
00006040009 // 13 Write immediate 3, JZ
00004040009 // 14 Write immediate 2, JZ
00000000000 // 15 Unused
1C000000081 // 16 Write R0 + R1
14000030081 // 17 Write R0 ^ R1, CRTN
